//--- all.f
+incdir+.
d3s_pkg.sv
phase_rl_encoder.sv
record_fifo.sv
phase_rl_decoder.sv
d3s_phase_link.sv
d3s_phase_link_chk.sv
tb_d3s_phase_link.sv

//--- Bender.yml
package:
  name: d3s_phase_link

export_include_dirs:
  - .

sources:
  - files:
      - d3s_pkg.sv
      - phase_rl_encoder.sv
      - record_fifo.sv
      - phase_rl_decoder.sv
      - d3s_phase_link.sv
  - target: test
    files:
      - d3s_phase_link_chk.sv
      - tb_d3s_phase_link.sv

//--- tb_d3s_phase_link.sv
`timescale 1ns/1ps
`default_nettype none

`include "d3s_defs.svh"

module tb_d3s_phase_link;
   import d3s_pkg::*;

   localparam int N_ROWS = 6;
   localparam int HALF   = 1 << (`D3S_PHASE_W - 1);
   localparam int FULL   = 1 << `D3S_PHASE_W;

   typedef struct packed {
      phase_t       start;
      phase_t       slope;
      logic [15:0]  count;
      logic [7:0]   noise;        // noise amplitude, plus or minus
      phase_t       err_max;
      rl_len_t      len_max;
      logic         expect_ovf;   // decoder held off for the whole row
   } row_t;

   logic     clk_wr = 1'b0;
   logic     clk_adc;
   logic     enc_enable;
   logic     dec_enable;
   logic     phase_valid;
   phase_t   phase_in;
   cycles_t  tm_in;
   phase_t   err_max;
   rl_len_t  length_max;
   phase_t   phase_out;
   cycles_t  tm_out;
   logic     valid_out;
   logic     overflow;

   row_t     rows [N_ROWS];
   logic     table_ready = 1'b0;
   integer   seed = 32'hdd03;
   int       mism_count = 0;
   int       other_count = 0;
   phase_t   exp_phase [$];
   cycles_t  exp_tm [$];
   phase_t   exp_tol [$];

   always #2 clk_wr = ~clk_wr;

   d3s_phase_link u_dut
   (
      .clk_wr        (clk_wr),
      .clk_adc       (clk_adc),
      .enc_enable_i  (enc_enable),
      .dec_enable_i  (dec_enable),
      .phase_valid_i (phase_valid),
      .phase_i       (phase_in),
      .tm_cycles_i   (tm_in),
      .err_max_i     (err_max),
      .length_max_i  (length_max),
      .phase_o       (phase_out),
      .tm_cycles_o   (tm_out),
      .phase_valid_o (valid_out),
      .overflow_o    (overflow)
   );

   // shortest way round the phase circle
   function automatic int circle_gap(phase_t a, phase_t b);
      int d;
      d = int'(a) - int'(b);
      if (d > HALF)
         d = d - FULL;
      else if (d < -HALF)
         d = d + FULL;
      return (d < 0) ? -d : d;
   endfunction

   task automatic compare_phase(phase_t got, phase_t exp, phase_t tol);
      if (circle_gap(got, exp) > int'(tol))
      begin
         mism_count++;
         $display("Mismatch at %0t: phase_o got %h expected %h (tol %0d)",
                  $time, got, exp, tol);
      end
   endtask

   task automatic compare_cycles(cycles_t got, cycles_t exp);
      if (got !== exp)
      begin
         mism_count++;
         $display("Mismatch at %0t: tm_cycles_o got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic compare_flag(string name, logic got, logic exp);
      if (got !== exp)
      begin
         mism_count++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // start, slope, count, noise, err_max, length_max, expect overflow
   task automatic fill_table();
      rows[0] = '{23'h001234, 23'h000100, 16'd64, 8'd0, 23'd0, 12'hfff, 1'b0};
      rows[1] = '{23'h0004a0, 23'h7fff00, 16'd50, 8'd0, 23'd3, 12'd100, 1'b0};
      rows[2] = '{23'h200000, 23'h000357, 16'd120, 8'd6, 23'd12, 12'd64, 1'b0};
      rows[3] = '{23'h123456, 23'h3ffffa, 16'd24, 8'd0, 23'd4, 12'd16, 1'b0};  // fixed only
      rows[4] = '{23'h7f0000, 23'h000a30, 16'd300, 8'd0, 23'd0, 12'd8, 1'b0};  // wraps
      rows[5] = '{23'h000000, 23'h3ffffa, 16'd40, 8'd0, 23'd0, 12'd8, 1'b1};
   endtask

   task automatic next_cycle();
      @(posedge clk_wr);
      #0.5;
      tm_in = tm_in + 1'b1;   // free running cycle count
   endtask

   task automatic run_row(int r);
      phase_t  ideal;
      phase_t  smp;
      int      nz;
      int      k;
      int      waited;
      ideal      = rows[r].start;
      smp        = ideal;
      err_max    = rows[r].err_max;
      length_max = rows[r].len_max;
      dec_enable = ~rows[r].expect_ovf;
      for (k = 0; k < int'(rows[r].count); k++)
      begin
         next_cycle();
         nz = 0;
         if (rows[r].noise != 0)
            nz = $random(seed) % (int'(rows[r].noise) + 1);
         smp         = ideal + phase_t'(nz);
         enc_enable  = 1'b1;
         phase_valid = 1'b1;
         phase_in    = smp;
         if (!rows[r].expect_ovf)
         begin
            exp_phase.push_back(smp);
            exp_tm.push_back(tm_in);
            exp_tol.push_back((rows[r].noise == 0) ? phase_t'(0) : rows[r].err_max);
         end
         ideal = ideal + rows[r].slope;
      end
      // still on the line so only the strobe ends the run
      next_cycle();
      phase_valid = 1'b0;
      phase_in    = ideal;
      next_cycle();
      enc_enable = 1'b0;
      if (rows[r].expect_ovf)
      begin
         repeat (4) next_cycle();
         compare_flag("overflow_o", overflow, 1'b1);
         repeat (8) next_cycle();
         compare_flag("overflow_o", overflow, 1'b1);   // must still hold
      end
      else
      begin
         waited = 0;
         while (exp_phase.size() != 0 && waited < 200)
         begin
            next_cycle();
            waited++;
         end
         if (exp_phase.size() != 0)
         begin
            other_count++;
            $display("row %0d: %0d driven samples were never decoded", r, exp_phase.size());
            exp_phase.delete();
            exp_tm.delete();
            exp_tol.delete();
         end
         compare_flag("overflow_o", overflow, 1'b0);
      end
   endtask

   // decoded samples come back in driven order
   always @(negedge clk_wr)
   begin
      if (clk_adc && valid_out)
      begin
         if (exp_phase.size() == 0)
         begin
            other_count++;
            $display("decoded sample at %0t has no driven sample to match", $time);
         end
         else
         begin
            compare_phase(phase_out, exp_phase.pop_front(), exp_tol.pop_front());
            compare_cycles(tm_out, exp_tm.pop_front());
         end
      end
   end

   initial
   begin
      longint  limit;
      int      r;
      wait (table_ready);
      limit = 2000;
      for (r = 0; r < N_ROWS; r++)
         limit = limit + 20 * longint'(rows[r].count);
      repeat (limit) @(posedge clk_wr);
      $display("watchdog expired after %0d cycles, the tests did not finish", limit);
      $display("TB FAILED");
      $finish;
   end

   initial
   begin
      int  r;
      int  assert_fails;
      clk_adc     = 1'b0;
      enc_enable  = 1'b0;
      dec_enable  = 1'b0;
      phase_valid = 1'b0;
      phase_in    = '0;
      tm_in       = 28'hfffff00;   // timestamp wraps early in the run
      err_max     = '0;
      length_max  = '0;
      fill_table();
      table_ready = 1'b1;
      repeat (16) @(posedge clk_wr);
      #0.5;
      clk_adc = 1'b1;
      for (r = 0; r < N_ROWS; r++)
         run_row(r);
      assert_fails = u_dut.u_chk.fail_count;
      $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mism_count, other_count, assert_fails);
      if (mism_count == 0 && other_count == 0 && assert_fails == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- d3s_phase_link_chk.sv
`timescale 1ns/1ps
`default_nettype none

module d3s_phase_link_chk
(
   input  wire logic              clk_wr,
   input  wire logic              clk_adc,
   input  wire logic              dec_pop_i,
   input  wire logic              fifo_empty_i,
   input  wire logic              phase_valid_i,
   input  wire d3s_pkg::phase_t   phase_i,
   input  wire d3s_pkg::cycles_t  tm_cycles_i,
   input  wire logic              overflow_i
);
   int fail_count = 0;   // summed up by the testbench

   // strobes and flags known once out of reset
   flags_known: assert property (@(posedge clk_wr) disable iff (!clk_adc)
      !$isunknown({phase_valid_i, overflow_i, dec_pop_i}))
      else
      begin
         fail_count++;
         $error("strobe or overflow flag unknown after reset");
      end

   sample_known: assert property (@(posedge clk_wr) disable iff (!clk_adc)
      phase_valid_i |-> !$isunknown({phase_i, tm_cycles_i}))
      else
      begin
         fail_count++;
         $error("decoded sample carries unknown bits");
      end

   no_pop_empty: assert property (@(posedge clk_wr) disable iff (!clk_adc)
      dec_pop_i |-> !fifo_empty_i)
      else
      begin
         fail_count++;
         $error("decoder popped an empty record FIFO");
      end

   // sticky until reset
   ovf_sticky: assert property (@(posedge clk_wr) disable iff (!clk_adc)
      overflow_i |=> overflow_i)
      else
      begin
         fail_count++;
         $error("overflow flag dropped without reset");
      end

endmodule

bind d3s_phase_link d3s_phase_link_chk u_chk
(
   .clk_wr        (clk_wr),
   .clk_adc       (clk_adc),
   .dec_pop_i     (dec_pop),
   .fifo_empty_i  (fifo_empty),
   .phase_valid_i (phase_valid_o),
   .phase_i       (phase_o),
   .tm_cycles_i   (tm_cycles_o),
   .overflow_i    (overflow_o)
);

`default_nettype wire

//--- d3s_phase_link.sv
`timescale 1ns/1ps
`default_nettype none

module d3s_phase_link
(
   input  wire logic              clk_wr,
   input  wire logic              clk_adc,
   input  wire logic              enc_enable_i,
   input  wire logic              dec_enable_i,
   input  wire logic              phase_valid_i,
   input  wire d3s_pkg::phase_t   phase_i,
   input  wire d3s_pkg::cycles_t  tm_cycles_i,
   input  wire d3s_pkg::phase_t   err_max_i,
   input  wire d3s_pkg::rl_len_t  length_max_i,
   output d3s_pkg::phase_t        phase_o,
   output d3s_pkg::cycles_t       tm_cycles_o,
   output logic                   phase_valid_o,
   output logic                   overflow_o
);
   import d3s_pkg::*;

   record_t  rec_word;
   logic     rec_valid;
   record_t  fifo_rdata;
   logic     fifo_empty;
   logic     dec_pop;

   phase_rl_encoder u_enc
   (
      .clk_wr        (clk_wr),
      .clk_adc       (clk_adc),
      .enc_enable_i  (enc_enable_i),
      .phase_valid_i (phase_valid_i),
      .phase_i       (phase_i),
      .tm_cycles_i   (tm_cycles_i),
      .err_max_i     (err_max_i),
      .length_max_i  (length_max_i),
      .rec_o         (rec_word),
      .rec_valid_o   (rec_valid)
   );

   // full only matters inside, it drops the word and flags overflow
   record_fifo u_fifo
   (
      .clk_wr     (clk_wr),
      .clk_adc    (clk_adc),
      .wdata_i    (rec_word),
      .push_i     (rec_valid),
      .pop_i      (dec_pop),
      .rdata_o    (fifo_rdata),
      .full_o     (),
      .empty_o    (fifo_empty),
      .overflow_o (overflow_o)
   );

   phase_rl_decoder u_dec
   (
      .clk_wr        (clk_wr),
      .clk_adc       (clk_adc),
      .dec_enable_i  (dec_enable_i),
      .rdata_i       (fifo_rdata),
      .empty_i       (fifo_empty),
      .pop_o         (dec_pop),
      .phase_o       (phase_o),
      .tm_cycles_o   (tm_cycles_o),
      .phase_valid_o (phase_valid_o)
   );

endmodule

`default_nettype wire

//--- phase_rl_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "d3s_defs.svh"

module phase_rl_decoder
(
   input  wire logic              clk_wr,
   input  wire logic              clk_adc,
   input  wire logic              dec_enable_i,
   input  wire d3s_pkg::record_t  rdata_i,
   input  wire logic              empty_i,
   output logic                   pop_o,
   output d3s_pkg::phase_t        phase_o,
   output d3s_pkg::cycles_t       tm_cycles_o,
   output logic                   phase_valid_o
);
   import d3s_pkg::*;

   dec_state_e  state_q;
   phase_t      integ_q;      // last reconstructed phase
   rl_delta_t   slope_q;
   rl_len_t     remain_q;     // samples left in the run
   cycles_t     tcnt_q;       // timestamp of the next sample

   logic        is_rl, is_ts;
   rl_delta_t   rec_slope;
   rl_len_t     rec_len;
   phase_t      rec_step, step_q;
   logic        expand;
   logic        emit;
   phase_t      emit_phase;

   // record fields
   assign is_rl     = rdata_i[`D3S_REC_RL_BIT];
   assign is_ts     = ~is_rl & rdata_i[`D3S_REC_TS_BIT];
   assign rec_slope = rl_delta_t'(rdata_i[`D3S_RL_DELTA_W-1:0]);
   assign rec_len   = rdata_i[`D3S_RL_DELTA_W +: `D3S_RL_LEN_W];
   assign rec_step  = phase_t'({rec_slope, {`D3S_RL_DELTA_SHIFT{1'b0}}});
   assign step_q    = phase_t'({slope_q, {`D3S_RL_DELTA_SHIFT{1'b0}}});

   assign pop_o  = (state_q == FETCH) & dec_enable_i & ~empty_i;
   assign expand = (state_q == EXPAND) & dec_enable_i;

   // first run sample comes straight from the pop
   assign emit = pop_o ? (is_rl ? (rec_len != '0) : ~is_ts) : expand;
   assign emit_phase = (pop_o && !is_rl) ? phase_t'(rdata_i[`D3S_PHASE_W-1:0])
                                          : integ_q + (pop_o ? rec_step : step_q);

   always_ff @(posedge clk_wr or negedge clk_adc)
   begin
      if (!clk_adc)
      begin
         state_q       <= FETCH;
         remain_q      <= '0;
         phase_valid_o <= 1'b0;
      end
      else
      begin
         phase_valid_o <= emit;
         if (pop_o && is_rl && rec_len > rl_len_t'(1))
         begin
            state_q  <= EXPAND;
            remain_q <= rec_len - 1'b1;
         end
         else if (expand)
         begin
            remain_q <= remain_q - 1'b1;
            if (remain_q == rl_len_t'(1))
               state_q <= FETCH;   // next record in the following cycle
         end
      end
   end

   always_ff @(posedge clk_wr)
   begin
      if (pop_o && is_rl)
         slope_q <= rec_slope;
      if (pop_o && is_ts)
         tcnt_q <= rdata_i[`D3S_CYCLES_W-1:0];
      else if (emit)
      begin
         integ_q     <= emit_phase;
         phase_o     <= emit_phase;
         tm_cycles_o <= tcnt_q;
         tcnt_q      <= tcnt_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- record_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "d3s_defs.svh"

module record_fifo
#(
   parameter int DEPTH = `D3S_FIFO_DEPTH   // power of two, 4 or more
)
(
   input  wire logic              clk_wr,
   input  wire logic              clk_adc,
   input  wire d3s_pkg::record_t  wdata_i,
   input  wire logic              push_i,
   input  wire logic              pop_i,
   output d3s_pkg::record_t       rdata_o,
   output logic                   full_o,
   output logic                   empty_o,
   output logic                   overflow_o
);
   import d3s_pkg::*;

   localparam int AW = $clog2(DEPTH);

   record_t         mem [DEPTH];
   logic [AW-1:0]   wr_ptr_q, rd_ptr_q;   // wrap naturally
   logic [AW:0]     count_q;
   logic            do_push, do_pop;

   assign full_o  = (count_q == (AW+1)'(DEPTH));
   assign empty_o = (count_q == '0);
   assign do_push = push_i & ~full_o;    // word dropped when full
   assign do_pop  = pop_i & ~empty_o;
   assign rdata_o = mem[rd_ptr_q];       // head word, no read latency

   always_ff @(posedge clk_wr or negedge clk_adc)
   begin
      if (!clk_adc)
      begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_o <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (do_push && !do_pop)
            count_q <= count_q + 1'b1;
         else if (do_pop && !do_push)
            count_q <= count_q - 1'b1;
         if (push_i && full_o)
            overflow_o <= 1'b1;   // sticky until reset
      end
   end

   always_ff @(posedge clk_wr)
   begin
      if (do_push)
         mem[wr_ptr_q] <= wdata_i;
   end

endmodule

`default_nettype wire

//--- phase_rl_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "d3s_defs.svh"

module phase_rl_encoder
(
   input  wire logic              clk_wr,
   input  wire logic              clk_adc,
   input  wire logic              enc_enable_i,
   input  wire logic              phase_valid_i,
   input  wire d3s_pkg::phase_t   phase_i,
   input  wire d3s_pkg::cycles_t  tm_cycles_i,
   input  wire d3s_pkg::phase_t   err_max_i,
   input  wire d3s_pkg::rl_len_t  length_max_i,
   output d3s_pkg::record_t       rec_o,
   output logic                   rec_valid_o
);
   import d3s_pkg::*;

   localparam logic signed [`D3S_PHASE_W:0] RND_HALF = 1 <<< (`D3S_RL_DELTA_SHIFT - 1);

   enc_state_e state_q, state_d;
   phase_t     integ_q, integ_d;         // what the decoder holds after the last sample
   rl_delta_t  slope_q, slope_d;
   rl_len_t    run_len_q, run_len_d;     // zero when no run is open
   logic       fix_pend_q, fix_pend_d;
   phase_t     fix_phase_q, fix_phase_d;

   logic                           sample_v;
   phase_t                         step_q;
   phase_t                         diff;
   logic signed [`D3S_PHASE_W:0]   diff_ext;
   logic signed [`D3S_PHASE_W:0]   diff_rnd;
   rl_delta_t                      new_slope;
   phase_t                         new_step;
   logic                           new_ok;
   logic                           grow_ok;
   record_t                        ts_word, fix_word, rl_word;

   // distance on the phase circle
   function automatic phase_t wrap_dist(phase_t a, phase_t b);
      phase_t d;
      d = a - b;
      return d[`D3S_PHASE_W-1] ? phase_t'(-d) : d;
   endfunction

   assign sample_v = phase_valid_i & enc_enable_i;
   assign step_q   = phase_t'({slope_q, {`D3S_RL_DELTA_SHIFT{1'b0}}});

   // slope candidate for a new run, rounded to the nearest unit
   assign diff      = phase_i - integ_q;
   assign diff_ext  = {diff[`D3S_PHASE_W-1], diff};
   assign diff_rnd  = (diff_ext + RND_HALF) >>> `D3S_RL_DELTA_SHIFT;
   assign new_slope = rl_delta_t'(diff_rnd[`D3S_RL_DELTA_W-1:0]);
   assign new_step  = phase_t'({new_slope, {`D3S_RL_DELTA_SHIFT{1'b0}}});
   assign new_ok    = (diff_rnd[`D3S_RL_DELTA_W] == diff_rnd[`D3S_RL_DELTA_W-1])
                      && (wrap_dist(phase_i, integ_q + new_step) <= err_max_i);

   assign grow_ok = sample_v && (run_len_q != '0) && (run_len_q < length_max_i)
                    && (wrap_dist(phase_i, integ_q + step_q) <= err_max_i);

   always_comb
   begin
      ts_word = '0;
      ts_word[`D3S_REC_TS_BIT] = 1'b1;
      ts_word[`D3S_CYCLES_W-1:0] = tm_cycles_i;
      fix_word = '0;
      fix_word[`D3S_PHASE_W-1:0] = fix_phase_q;
      rl_word = '0;
      rl_word[`D3S_REC_RL_BIT] = 1'b1;
      rl_word[`D3S_RL_DELTA_W +: `D3S_RL_LEN_W] = run_len_q;
      rl_word[`D3S_RL_DELTA_W-1:0] = slope_q;
   end

   always_comb
   begin
      state_d     = state_q;
      integ_d     = integ_q;
      slope_d     = slope_q;
      run_len_d   = run_len_q;
      fix_pend_d  = fix_pend_q;
      fix_phase_d = fix_phase_q;
      rec_o       = '0;
      rec_valid_o = 1'b0;
      case (state_q)
         IDLE:
         begin
            if (sample_v)
            begin
               rec_o       = ts_word;     // timestamp goes out with the first sample
               rec_valid_o = 1'b1;
               integ_d     = phase_i;
               fix_phase_d = phase_i;
               fix_pend_d  = 1'b1;
               run_len_d   = '0;
               state_d     = RUN;
            end
         end
         RUN:
         begin
            if (fix_pend_q)
            begin
               rec_o       = fix_word;
               rec_valid_o = 1'b1;
            end
            else if (run_len_q != '0 && !grow_ok)
            begin
               rec_o       = rl_word;     // flush, also on end of stream
               rec_valid_o = 1'b1;
            end

            if (!sample_v)
            begin
               state_d    = IDLE;
               fix_pend_d = 1'b0;
               run_len_d  = '0;
            end
            else if (grow_ok)
            begin
               run_len_d = run_len_q + 1'b1;
               integ_d   = integ_q + step_q;
            end
            else if (new_ok)
            begin
               fix_pend_d = 1'b0;
               slope_d    = new_slope;
               run_len_d  = rl_len_t'(1);
               integ_d    = integ_q + new_step;
            end
            else
            begin
               // slope unusable, send the sample as it is next cycle
               fix_pend_d  = 1'b1;
               fix_phase_d = phase_i;
               integ_d     = phase_i;
               run_len_d   = '0;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_wr or negedge clk_adc)
   begin
      if (!clk_adc)
      begin
         state_q    <= IDLE;
         run_len_q  <= '0;
         fix_pend_q <= 1'b0;
      end
      else
      begin
         state_q    <= state_d;
         run_len_q  <= run_len_d;
         fix_pend_q <= fix_pend_d;
      end
   end

   always_ff @(posedge clk_wr)
   begin
      integ_q     <= integ_d;
      slope_q     <= slope_d;
      fix_phase_q <= fix_phase_d;
   end

endmodule

`default_nettype wire

//--- d3s_pkg.sv
`default_nettype none

`include "d3s_defs.svh"

package d3s_pkg;

   // phase sample, arithmetic wraps
   typedef logic [`D3S_PHASE_W-1:0] phase_t;

   // timestamp counted in cycles
   typedef logic [`D3S_CYCLES_W-1:0] cycles_t;

   // one word as stored in the record FIFO
   typedef logic [`D3S_REC_W-1:0] record_t;

   // signed slope, scaled by 16 before use
   typedef logic signed [`D3S_RL_DELTA_W-1:0] rl_delta_t;

   typedef logic [`D3S_RL_LEN_W-1:0] rl_len_t;

   // encoder: IDLE until a valid sample arrives, RUN while the stream lasts
   typedef enum logic {
      IDLE,
      RUN
   } enc_state_e;

   // decoder: FETCH pops a record, EXPAND plays out the rest of a run
   typedef enum logic {
      FETCH,
      EXPAND
   } dec_state_e;

endpackage

`default_nettype wire

//--- d3s_defs.svh
`ifndef D3S_DEFS_SVH
`define D3S_DEFS_SVH

// sample stream
`define D3S_PHASE_W 23    // phase wraps modulo 2^23
`define D3S_CYCLES_W 28   // timestamp in cycles

// record word layout
`define D3S_REC_W 32

// marker bits, checked in this order
`define D3S_REC_RL_BIT 31 // run-length record
`define D3S_REC_TS_BIT 30 // timestamp record when rl bit is clear

// run-length record fields
// slope sits in the low bits, the run length right above it
`define D3S_RL_DELTA_W 19
`define D3S_RL_DELTA_SHIFT 4 // slope counted in units of 16
`define D3S_RL_LEN_W 12

// fixed records hold the phase in the low bits
// timestamp records hold the cycle count in the low bits

// record buffer between encoder and decoder
`define D3S_FIFO_DEPTH 16

`endif
